// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = controlUnit_tb
FILELIST = controlUnit.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) include/control_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

// File: controlUnit.f
+incdir+include
source/isaPkg.sv
source/controlPkg.sv
source/instrDecoder.sv
source/controlWordGen.sv
source/exceptionUnit.sv
source/controlUnit.sv
test/controlUnit_assertions.sv
test/controlUnit_tb.sv

// File: include/control_settings.svh
//*********************************************************************
// Control unit settings
// instruction field widths and the interrupt line count
//*********************************************************************

`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// instruction fields
`define CU_OPCODE_W 6
`define CU_FUNCT_W 6
`define CU_FMT_W 5

// COP0 cause register
`define CU_EXCCODE_W 5

// hardware and software interrupt lines
`define CU_INT_LINES 8

`endif

// File: source/controlPkg.sv
//*********************************************************************
// Control word and COP0 types
// datapath selectors, exception codes and the status bundle
//*********************************************************************

`include "control_settings.svh"

package controlPkg;

	typedef enum logic [2:0] {
		pcNext = 3'd0,
		pcBeq  = 3'd1,
		pcJump = 3'd2,
		pcReg  = 3'd3,
		pcExc  = 3'd4,
		pcBne  = 3'd5
	} pcSrcT;

	// codes 1 and 4 belonged to the FPU write-back paths
	typedef enum logic [2:0] {
		aluResult = 3'd0,
		linkPc    = 3'd2,
		upperImm  = 3'd3,
		cop0Data  = 3'd5,
		memData   = 3'd6,
		moveData  = 3'd7
	} memToRegT;

	typedef enum logic [1:0] {
		rt = 2'd0,
		rd = 2'd1,
		ra = 2'd2
	} regDstT;

	typedef enum logic [1:0] {
		regB    = 2'd0,
		signImm = 2'd1,
		zeroImm = 2'd2
	} aluSrcT;

	typedef enum logic [1:0] {
		aluAdd   = 2'd0,
		aluSub   = 2'd1,
		aluFunct = 2'd2,
		aluImm   = 2'd3
	} aluOpT;

	typedef enum logic [`CU_EXCCODE_W-1:0] {
		excInt      = 5'd0,
		excSys      = 5'd8,
		excInstr    = 5'd10,
		excOverflow = 5'd12
	} excCodeT;

	typedef struct packed {
		regDstT   regDst;
		aluSrcT   aluSrc;
		memToRegT memToReg;
		logic     regWrite;
		logic     memRead;
		logic     memWrite;
		pcSrcT    pcSrc;
		aluOpT    aluOp;
	} ctrlWordT;

	typedef struct packed {
		logic    cop0Write;
		logic    eret;
		logic    excOccurred;
		logic    branchDelay;
		excCodeT excCode;
	} cop0CtrlT;

	typedef struct packed {
		logic                     excLevel;
		logic                     userMode;
		logic                     aluOverflow;
		logic [`CU_INT_LINES-1:0] pendingInt;
	} cpuStatusT;

endpackage

// File: source/controlUnit.sv
//*********************************************************************
// Main control unit
// decode, control word and exception stages in one combinational path
//*********************************************************************

`timescale 1ns/1ps

module controlUnit
	import isaPkg::*;
	import controlPkg::*;
(
	input  opcodeT    opcode,
	input  functT     funct,
	input  fmtT       fmt,
	input  logic      equalZero,
	input  cpuStatusT status,
	output ctrlWordT  ctrl,
	output cop0CtrlT  cop0
);

	instrClassT instrClass;

	instrDecoder decoder_i (
		.opcode     (opcode),
		.funct      (funct),
		.fmt        (fmt),
		.instrClass (instrClass)
	);

	controlWordGen wordGen_i (
		.instrClass (instrClass),
		.equalZero  (equalZero),
		.ctrl       (ctrl)
	);

	exceptionUnit excUnit_i (
		.instrClass (instrClass),
		.status     (status),
		.cop0       (cop0)
	);

endmodule

// File: source/controlWordGen.sv
//*********************************************************************
// Datapath control word generator
// selectors and write enables for each instruction class
//*********************************************************************

`timescale 1ns/1ps

module controlWordGen
	import isaPkg::*;
	import controlPkg::*;
(
	input  instrClassT instrClass,
	input  logic       equalZero,
	output ctrlWordT   ctrl
);

	always_comb
	begin
		// idle word, also used for mtc0 and invalid
		ctrl = '0;
		case (instrClass)
			clsLoad:
			begin
				ctrl.aluSrc = signImm;
				ctrl.memToReg = memData;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
			end
			clsStore:
			begin
				ctrl.aluSrc = signImm;
				ctrl.memWrite = 1'b1;
			end
			clsBeq:
			begin
				ctrl.pcSrc = pcBeq;
				ctrl.aluOp = aluSub;
			end
			clsBne:
			begin
				ctrl.pcSrc = pcBne;
				ctrl.aluOp = aluSub;
			end
			clsJump:
			begin
				ctrl.regDst = rd;
				ctrl.pcSrc = pcJump;
			end
			clsJal:
			begin
				// return address goes to $ra
				ctrl.regDst = ra;
				ctrl.memToReg = linkPc;
				ctrl.regWrite = 1'b1;
				ctrl.pcSrc = pcJump;
			end
			clsJr:
				ctrl.pcSrc = pcReg;
			clsSyscall, clsEret:
				ctrl.pcSrc = pcExc;
			clsAluR, clsAddTrapR:
			begin
				ctrl.regDst = rd;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluFunct;
			end
			clsAddiTrap, clsAluImm:
			begin
				ctrl.aluSrc = signImm;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluImm;
			end
			clsLogicImm:
			begin
				ctrl.aluSrc = zeroImm;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluImm;
			end
			clsLui:
			begin
				ctrl.memToReg = upperImm;
				ctrl.regWrite = 1'b1;
			end
			clsMovz:
			begin
				ctrl.regDst = rd;
				ctrl.memToReg = moveData;
				ctrl.regWrite = equalZero;
			end
			clsMovn:
			begin
				ctrl.regDst = rd;
				ctrl.memToReg = moveData;
				ctrl.regWrite = ~equalZero;
				ctrl.aluOp = aluSub;
			end
			clsMfc0:
			begin
				ctrl.memToReg = cop0Data;
				ctrl.regWrite = 1'b1;
			end
			default:
				ctrl = '0;
		endcase
	end

endmodule

// File: source/exceptionUnit.sv
//*********************************************************************
// COP0 exception detection
// raises exceptions from the instruction class and processor status
//*********************************************************************

`timescale 1ns/1ps

module exceptionUnit
	import isaPkg::*;
	import controlPkg::*;
(
	input  instrClassT instrClass,
	input  cpuStatusT  status,
	output cop0CtrlT   cop0
);

	logic intPending;
	logic kernelMode;
	logic intExc;

	assign intPending = |status.pendingInt;
	assign kernelMode = ~status.userMode;
	// an exception handler already running masks everything
	assign intExc = intPending & ~status.excLevel;

	always_comb
	begin
		cop0.cop0Write = (instrClass == clsMtc0) & kernelMode;
		cop0.eret = (instrClass == clsEret) & kernelMode;
		cop0.branchDelay = (instrClass == clsBeq) || (instrClass == clsBne) ||
			(instrClass == clsJump) || (instrClass == clsJal) || (instrClass == clsJr);
		cop0.excOccurred = intExc;
		cop0.excCode = excInt;
		case (instrClass)
			clsAddTrapR, clsAddiTrap, clsMovz, clsMovn:
			begin
				cop0.excOccurred = (status.aluOverflow | intPending) & ~status.excLevel;
				cop0.excCode = status.aluOverflow ? excOverflow : excInt;
			end
			clsSyscall:
			begin
				cop0.excOccurred = ~status.excLevel;
				cop0.excCode = excSys;
			end
			clsInvalid:
			begin
				cop0.excOccurred = ~status.excLevel;
				cop0.excCode = excInstr;
			end
			// privileged, trap from user mode
			clsMfc0, clsMtc0, clsEret:
			begin
				cop0.excOccurred = status.userMode;
				cop0.excCode = excInstr;
			end
			default:
			begin
				cop0.excOccurred = intExc;
				cop0.excCode = excInt;
			end
		endcase
	end

endmodule

// File: source/instrDecoder.sv
//*********************************************************************
// Instruction decoder
// reduces opcode, funct and fmt to a single instruction class
//*********************************************************************

`timescale 1ns/1ps

module instrDecoder
	import isaPkg::*;
(
	input  opcodeT     opcode,
	input  functT      funct,
	input  fmtT        fmt,
	output instrClassT instrClass
);

	always_comb
	begin
		instrClass = clsInvalid;
		case (opcode)
			opLb, opLh, opLw, opLbu, opLhu:
				instrClass = clsLoad;
			opSb, opSh, opSw:
				instrClass = clsStore;
			opBeq:
				instrClass = clsBeq;
			opBne:
				instrClass = clsBne;
			opJ:
				instrClass = clsJump;
			opJal:
				instrClass = clsJal;
			opAddi:
				instrClass = clsAddiTrap;
			opAddiu, opSlti, opSltiu:
				instrClass = clsAluImm;
			opAndi, opOri, opXori:
				instrClass = clsLogicImm;
			opLui:
				instrClass = clsLui;
			opRfmt:
			begin
				case (funct)
					fnJr:
						instrClass = clsJr;
					fnSyscall:
						instrClass = clsSyscall;
					fnMovz:
						instrClass = clsMovz;
					fnMovn:
						instrClass = clsMovn;
					// only these two trap on overflow
					fnAdd, fnSub:
						instrClass = clsAddTrapR;
					fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav,
					fnMfhi, fnMthi, fnMflo, fnMtlo,
					fnMult, fnMultu, fnDiv, fnDivu,
					fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor,
					fnSlt, fnSltu:
						instrClass = clsAluR;
					default:
						instrClass = clsInvalid;
				endcase
			end
			opCop0:
			begin
				case (fmt)
					fmtMf:
						instrClass = clsMfc0;
					fmtMt:
						instrClass = clsMtc0;
					fmtCo:
						instrClass = (funct == fnEret) ? clsEret : clsInvalid;
					default:
						instrClass = clsInvalid;
				endcase
			end
			default:
				instrClass = clsInvalid;
		endcase
	end

endmodule

// File: source/isaPkg.sv
//*********************************************************************
// ISA encodings
// opcode, funct and fmt fields and the decoded instruction class
//*********************************************************************

`include "control_settings.svh"

package isaPkg;

	// integer and COP0 opcodes only, FP opcodes fall to invalid
	typedef enum logic [`CU_OPCODE_W-1:0] {
		opRfmt  = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opAddiu = 6'h09,
		opSlti  = 6'h0A,
		opSltiu = 6'h0B,
		opAndi  = 6'h0C,
		opOri   = 6'h0D,
		opXori  = 6'h0E,
		opLui   = 6'h0F,
		opCop0  = 6'h10,
		opLb    = 6'h20,
		opLh    = 6'h21,
		opLw    = 6'h23,
		opLbu   = 6'h24,
		opLhu   = 6'h25,
		opSb    = 6'h28,
		opSh    = 6'h29,
		opSw    = 6'h2B
	} opcodeT;

	typedef enum logic [`CU_FUNCT_W-1:0] {
		fnSll     = 6'h00,
		fnSrl     = 6'h02,
		fnSra     = 6'h03,
		fnSllv    = 6'h04,
		fnSrlv    = 6'h06,
		fnSrav    = 6'h07,
		fnJr      = 6'h08,
		fnMovz    = 6'h0A,
		fnMovn    = 6'h0B,
		fnSyscall = 6'h0C,
		fnMfhi    = 6'h10,
		fnMthi    = 6'h11,
		fnMflo    = 6'h12,
		fnMtlo    = 6'h13,
		fnMult    = 6'h18,
		fnMultu   = 6'h19,
		fnDiv     = 6'h1A,
		fnDivu    = 6'h1B,
		fnAdd     = 6'h20,
		fnAddu    = 6'h21,
		fnSub     = 6'h22,
		fnSubu    = 6'h23,
		fnAnd     = 6'h24,
		fnOr      = 6'h25,
		fnXor     = 6'h26,
		fnNor     = 6'h27,
		fnSlt     = 6'h2A,
		fnSltu    = 6'h2B
	} functT;

	// eret shares its funct code with mult, only the cop0 co format tells them apart
	localparam functT fnEret = fnMult;

	typedef enum logic [`CU_FMT_W-1:0] {
		fmtMf = 5'h00,
		fmtMt = 5'h04,
		fmtCo = 5'h10
	} fmtT;

	typedef enum logic [4:0] {
		clsLoad,
		clsStore,
		clsBeq,
		clsBne,
		clsJump,
		clsJal,
		clsJr,
		clsSyscall,
		clsAluR,
		clsAddTrapR,
		clsAddiTrap,
		clsAluImm,
		clsLogicImm,
		clsLui,
		clsMovz,
		clsMovn,
		clsMfc0,
		clsMtc0,
		clsEret,
		clsInvalid
	} instrClassT;

endpackage

// File: test/controlUnit_assertions.sv
//*********************************************************************
// Control unit output checks
// concurrent properties on the control word and COP0 signals
//*********************************************************************

`timescale 1ns/1ps

module controlUnit_assertions
	import controlPkg::*;
(
	input logic      clk,
	input cpuStatusT status,
	input ctrlWordT  ctrl,
	input cop0CtrlT  cop0
);

	int failCount = 0;

	memExclusive: assert property (@(posedge clk) !(ctrl.memRead && ctrl.memWrite))
	else
	begin
		failCount++;
		$error("memory read and write enabled together");
	end

	// privileged writes only from kernel mode
	kernelOnly: assert property (@(posedge clk)
		(cop0.cop0Write || cop0.eret) |-> !status.userMode)
	else
	begin
		failCount++;
		$error("cop0 write or eret issued in user mode");
	end

	linkOnly: assert property (@(posedge clk)
		(cop0.branchDelay && ctrl.regWrite) |-> (ctrl.memToReg == linkPc))
	else
	begin
		failCount++;
		$error("control transfer writes a register other than the link address");
	end

endmodule

// File: test/controlUnit_tb.sv
//*********************************************************************
// Control unit testbench
// table of instructions with expected words, then a random status sweep
//*********************************************************************

`timescale 1ns/1ps

`include "control_settings.svh"

module controlUnit_tb
	import controlPkg::*;
();

	typedef struct packed {
		logic [5:0] opcode;
		logic [5:0] funct;
		logic [4:0] fmt;
		logic       equalZero;
		cpuStatusT  status;
		ctrlWordT   ctrl;
		cop0CtrlT   cop0;
	} vectorT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [5:0] funct;
		logic [4:0] fmt;
		logic [2:0] kind;
		logic       transfer;
		logic       writesCop0;
		logic       isEret;
	} sweepT;

	localparam logic on = 1'b1;
	localparam logic off = 1'b0;
	localparam logic [2:0] kindTrap = 3'd0;
	localparam logic [2:0] kindSys = 3'd1;
	localparam logic [2:0] kindInvalid = 3'd2;
	localparam logic [2:0] kindPriv = 3'd3;
	localparam logic [2:0] kindPlain = 3'd4;

	logic clk;
	logic rstN;
	isaPkg::opcodeT opcode;
	isaPkg::functT funct;
	isaPkg::fmtT fmt;
	logic equalZero;
	cpuStatusT status;
	ctrlWordT ctrl;
	cop0CtrlT cop0;

	int edgeCount = 0;
	realtime lastEdge = 0.0;
	vectorT vectors[$];
	sweepT sweepList[$];

	controlUnit dut_i (
		.opcode    (opcode),
		.funct     (funct),
		.fmt       (fmt),
		.equalZero (equalZero),
		.status    (status),
		.ctrl      (ctrl),
		.cop0      (cop0)
	);

	bind controlUnit controlUnit_assertions assert_i (
		.clk    (controlUnit_tb.clk),
		.status (status),
		.ctrl   (ctrl),
		.cop0   (cop0)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		edgeCount++;
		lastEdge = $realtime;
	end

	function automatic int unsigned nextRandom(input int unsigned state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cpuStatusT makeStatus(input logic lvl, input logic usr,
		input logic ovf, input logic [`CU_INT_LINES-1:0] ints);
		return cpuStatusT'{lvl, usr, ovf, ints};
	endfunction

	function automatic ctrlWordT makeCtrl(input regDstT d, input aluSrcT s,
		input memToRegT m, input logic w, input logic r, input logic mw,
		input pcSrcT p, input aluOpT o);
		return ctrlWordT'{d, s, m, w, r, mw, p, o};
	endfunction

	function automatic cop0CtrlT makeCop0(input logic wr, input logic er,
		input logic exc, input logic bd, input excCodeT code);
		return cop0CtrlT'{wr, er, exc, bd, code};
	endfunction

	// expected COP0 outputs from the exception rules
	function automatic cop0CtrlT expectCop0(input sweepT s, input cpuStatusT st);
		cop0CtrlT e;
		logic intr;
		intr = |st.pendingInt;
		e.cop0Write = s.writesCop0 & ~st.userMode;
		e.eret = s.isEret & ~st.userMode;
		e.branchDelay = s.transfer;
		case (s.kind)
			kindTrap:
			begin
				e.excOccurred = (st.aluOverflow | intr) & ~st.excLevel;
				e.excCode = st.aluOverflow ? excOverflow : excInt;
			end
			kindSys:
			begin
				e.excOccurred = ~st.excLevel;
				e.excCode = excSys;
			end
			kindInvalid:
			begin
				e.excOccurred = ~st.excLevel;
				e.excCode = excInstr;
			end
			kindPriv:
			begin
				e.excOccurred = st.userMode;
				e.excCode = excInstr;
			end
			default:
			begin
				e.excOccurred = intr & ~st.excLevel;
				e.excCode = excInt;
			end
		endcase
		return e;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Test failed");
			$fatal(1, "stopping on the first wrong value");
		end
	endtask

	// returns 2 ns after the n-th rising edge from now
	task automatic waitCycles(input int n);
		int target;
		int guard;
		target = edgeCount + n;
		guard = 0;
		while (edgeCount < target)
		begin
			if (guard > 50 * n)
			begin
				$display("timeout: the clock stopped producing rising edges");
				$display("Test failed");
				$fatal(1, "clock wait timed out");
			end
			else
			begin
				#1;
				guard++;
			end
		end
		#(lastEdge + 2.0 - $realtime);
	endtask

	task automatic applyInputs(input logic [5:0] op, input logic [5:0] fn,
		input logic [4:0] fm, input logic eq, input cpuStatusT st);
		opcode = isaPkg::opcodeT'(op);
		funct = isaPkg::functT'(fn);
		fmt = isaPkg::fmtT'(fm);
		equalZero = eq;
		status = st;
	endtask

	task automatic addRow(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] fm,
		input logic eq, input cpuStatusT st, input ctrlWordT c, input cop0CtrlT e);
		vectors.push_back(vectorT'{op, fn, fm, eq, st, c, e});
	endtask

	task automatic buildTable();
		cpuStatusT kern;
		cpuStatusT userSt;
		cpuStatusT lvlSt;
		cpuStatusT intSt;
		cpuStatusT ovfSt;
		ctrlWordT idle;
		ctrlWordT aluR;
		ctrlWordT immArith;
		ctrlWordT jumpCtrl;
		cop0CtrlT noExc;
		cop0CtrlT branchOnly;
		cop0CtrlT badInstr;
		kern = makeStatus(off, off, off, 8'h00);
		userSt = makeStatus(off, on, off, 8'h00);
		lvlSt = makeStatus(on, off, off, 8'h00);
		intSt = makeStatus(off, off, off, 8'h04);
		ovfSt = makeStatus(off, off, on, 8'h00);
		idle = makeCtrl(rt, regB, aluResult, off, off, off, pcNext, aluAdd);
		aluR = makeCtrl(rd, regB, aluResult, on, off, off, pcNext, aluFunct);
		immArith = makeCtrl(rt, signImm, aluResult, on, off, off, pcNext, aluImm);
		jumpCtrl = makeCtrl(rd, regB, aluResult, off, off, off, pcJump, aluAdd);
		noExc = makeCop0(off, off, off, off, excInt);
		branchOnly = makeCop0(off, off, off, on, excInt);
		badInstr = makeCop0(off, off, on, off, excInstr);
		addRow(6'h23, 6'h00, 5'h00, off, kern,
			makeCtrl(rt, signImm, memData, on, on, off, pcNext, aluAdd), noExc);
		addRow(6'h2B, 6'h00, 5'h00, off, kern,
			makeCtrl(rt, signImm, aluResult, off, off, on, pcNext, aluAdd), noExc);
		addRow(6'h04, 6'h00, 5'h00, off, kern,
			makeCtrl(rt, regB, aluResult, off, off, off, pcBeq, aluSub), branchOnly);
		addRow(6'h05, 6'h00, 5'h00, off, kern,
			makeCtrl(rt, regB, aluResult, off, off, off, pcBne, aluSub), branchOnly);
		addRow(6'h02, 6'h00, 5'h00, off, kern, jumpCtrl, branchOnly);
		addRow(6'h03, 6'h00, 5'h00, off, kern,
			makeCtrl(ra, regB, linkPc, on, off, off, pcJump, aluAdd), branchOnly);
		addRow(6'h00, 6'h08, 5'h00, off, kern,
			makeCtrl(rt, regB, aluResult, off, off, off, pcReg, aluAdd), branchOnly);
		addRow(6'h00, 6'h21, 5'h00, off, kern, aluR, noExc);
		addRow(6'h00, 6'h18, 5'h00, off, kern, aluR, noExc);
		addRow(6'h00, 6'h20, 5'h00, off, kern, aluR, noExc);
		addRow(6'h09, 6'h00, 5'h00, off, kern, immArith, noExc);
		addRow(6'h0E, 6'h00, 5'h00, off, kern,
			makeCtrl(rt, zeroImm, aluResult, on, off, off, pcNext, aluImm), noExc);
		addRow(6'h0F, 6'h00, 5'h00, off, kern,
			makeCtrl(rt, regB, upperImm, on, off, off, pcNext, aluAdd), noExc);
		// FP opcodes and the FP move funct are gone
		addRow(6'h31, 6'h00, 5'h00, off, kern, idle, badInstr);
		addRow(6'h11, 6'h00, 5'h00, off, kern, idle, badInstr);
		addRow(6'h00, 6'h01, 5'h00, off, kern, idle, badInstr);
		addRow(6'h00, 6'h0A, 5'h00, on, kern,
			makeCtrl(rd, regB, moveData, on, off, off, pcNext, aluAdd), noExc);
		addRow(6'h00, 6'h0A, 5'h00, off, kern,
			makeCtrl(rd, regB, moveData, off, off, off, pcNext, aluAdd), noExc);
		addRow(6'h00, 6'h0B, 5'h00, off, kern,
			makeCtrl(rd, regB, moveData, on, off, off, pcNext, aluSub), noExc);
		addRow(6'h00, 6'h0B, 5'h00, on, kern,
			makeCtrl(rd, regB, moveData, off, off, off, pcNext, aluSub), noExc);
		addRow(6'h00, 6'h20, 5'h00, off, ovfSt, aluR, makeCop0(off, off, on, off, excOverflow));
		addRow(6'h00, 6'h20, 5'h00, off, makeStatus(on, off, on, 8'h00), aluR,
			makeCop0(off, off, off, off, excOverflow));
		addRow(6'h08, 6'h00, 5'h00, off, intSt, immArith, makeCop0(off, off, on, off, excInt));
		addRow(6'h08, 6'h00, 5'h00, off, makeStatus(off, off, on, 8'h01), immArith,
			makeCop0(off, off, on, off, excOverflow));
		addRow(6'h00, 6'h0C, 5'h00, off, kern,
			makeCtrl(rt, regB, aluResult, off, off, off, pcExc, aluAdd),
			makeCop0(off, off, on, off, excSys));
		addRow(6'h00, 6'h0C, 5'h00, off, lvlSt,
			makeCtrl(rt, regB, aluResult, off, off, off, pcExc, aluAdd),
			makeCop0(off, off, off, off, excSys));
		addRow(6'h3F, 6'h00, 5'h00, off, lvlSt, idle, makeCop0(off, off, off, off, excInstr));
		// mfc0, mtc0 and eret from kernel then from user mode
		addRow(6'h10, 6'h00, 5'h00, off, kern,
			makeCtrl(rt, regB, cop0Data, on, off, off, pcNext, aluAdd),
			makeCop0(off, off, off, off, excInstr));
		addRow(6'h10, 6'h00, 5'h00, off, userSt,
			makeCtrl(rt, regB, cop0Data, on, off, off, pcNext, aluAdd), badInstr);
		addRow(6'h10, 6'h00, 5'h04, off, kern, idle, makeCop0(on, off, off, off, excInstr));
		addRow(6'h10, 6'h00, 5'h04, off, userSt, idle, badInstr);
		addRow(6'h10, 6'h18, 5'h10, off, kern,
			makeCtrl(rt, regB, aluResult, off, off, off, pcExc, aluAdd),
			makeCop0(off, on, off, off, excInstr));
		addRow(6'h10, 6'h18, 5'h10, off, userSt,
			makeCtrl(rt, regB, aluResult, off, off, off, pcExc, aluAdd), badInstr);
		addRow(6'h10, 6'h01, 5'h10, off, kern, idle, badInstr);
		addRow(6'h23, 6'h00, 5'h00, off, intSt,
			makeCtrl(rt, signImm, memData, on, on, off, pcNext, aluAdd),
			makeCop0(off, off, on, off, excInt));
		addRow(6'h23, 6'h00, 5'h00, off, makeStatus(on, off, off, 8'h80),
			makeCtrl(rt, signImm, memData, on, on, off, pcNext, aluAdd), noExc);
		addRow(6'h02, 6'h00, 5'h00, off, intSt, jumpCtrl, makeCop0(off, off, on, on, excInt));
	endtask

	task automatic buildSweep();
		sweepList.push_back(sweepT'{6'h00, 6'h20, 5'h00, kindTrap, off, off, off});
		sweepList.push_back(sweepT'{6'h08, 6'h00, 5'h00, kindTrap, off, off, off});
		sweepList.push_back(sweepT'{6'h00, 6'h0A, 5'h00, kindTrap, off, off, off});
		sweepList.push_back(sweepT'{6'h00, 6'h0C, 5'h00, kindSys, off, off, off});
		sweepList.push_back(sweepT'{6'h31, 6'h00, 5'h00, kindInvalid, off, off, off});
		sweepList.push_back(sweepT'{6'h10, 6'h00, 5'h04, kindPriv, off, on, off});
		sweepList.push_back(sweepT'{6'h10, 6'h18, 5'h10, kindPriv, off, off, on});
		sweepList.push_back(sweepT'{6'h10, 6'h00, 5'h00, kindPriv, off, off, off});
		sweepList.push_back(sweepT'{6'h23, 6'h00, 5'h00, kindPlain, off, off, off});
		sweepList.push_back(sweepT'{6'h04, 6'h00, 5'h00, kindPlain, on, off, off});
		sweepList.push_back(sweepT'{6'h03, 6'h00, 5'h00, kindPlain, on, off, off});
	endtask

	initial
	begin
		vectorT v;
		sweepT s;
		cpuStatusT st;
		int unsigned seed;
		int idx;
		clk = 1'b0;
		rstN = 1'b0;
		applyInputs(6'h00, 6'h00, 5'h00, 1'b0, cpuStatusT'('0));
		buildTable();
		buildSweep();
		waitCycles(10);
		rstN = 1'b1;
		for (int i = 0; i < vectors.size(); i++)
		begin
			v = vectors[i];
			waitCycles(1);
			applyInputs(v.opcode, v.funct, v.fmt, v.equalZero, v.status);
			#18;
			checkValue($sformatf("ctrl (row %0d)", i), 32'(ctrl), 32'(v.ctrl));
			checkValue($sformatf("cop0 (row %0d)", i), 32'(cop0), 32'(v.cop0));
		end
		seed = 32'd89;
		for (int n = 0; n < 60; n++)
		begin
			seed = nextRandom(seed);
			idx = int'(seed >> 24) % sweepList.size();
			s = sweepList[idx];
			seed = nextRandom(seed);
			st.excLevel = seed[16];
			st.userMode = seed[17];
			st.aluOverflow = seed[18];
			st.pendingInt = seed[19] ? seed[27:20] : 8'h00;
			waitCycles(1);
			applyInputs(s.opcode, s.funct, s.fmt, seed[28], st);
			#18;
			checkValue($sformatf("cop0 (sweep %0d)", n), 32'(cop0), 32'(expectCop0(s, st)));
		end
		waitCycles(1);
		if (dut_i.assert_i.failCount != 0)
		begin
			$display("an output property was violated during the run");
			$display("Test failed");
			$fatal(1, "output property failures");
		end
		else
		begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule
